// File: verilog/system_settings.svh
// ======================================================================
// System wide sizes. The memory depth and region bit must agree, since
// word index plus byte offset has to end right below the region bit.
// ======================================================================
`ifndef SYSTEM_SETTINGS_SVH
`define SYSTEM_SETTINGS_SVH

// 32-bit words in main memory (4 KB)
`define SYSTEM_MEM_WORDS 1024

// Address bit that splits memory from peripherals
`define SYSTEM_REGION_BIT 12

// Clock cycles per timer count tick
`define TIMER_PRESCALE 4

`endif

// File: verilog/bus_pkg.sv
// ======================================================================
// Bus address types. Field widths follow the memory depth and region bit.
// ======================================================================
`include "system_settings.svh"

package bus_pkg;

    localparam int WORD_W  = $clog2(`SYSTEM_MEM_WORDS);
    localparam int UPPER_W = 31 - `SYSTEM_REGION_BIT;

    typedef enum logic {
        REGION_MEM    = 1'b0,
        REGION_PERIPH = 1'b1
    } region_e;

    // Address split as seen by the decoders
    typedef struct packed {
        logic [UPPER_W-1:0] upper;
        region_e            region;
        logic [WORD_W-1:0]  word;
        logic [1:0]         offset;
    } sys_addr_fields_t;

    // Same 32 bits as raw word or field split
    typedef union packed {
        logic [31:0]      raw;
        sys_addr_fields_t fields;
    } sys_addr_u;

endpackage

// File: verilog/timer_pkg.sv
// ======================================================================
// Timer register map, control word layout and FSM states
// ======================================================================
package timer_pkg;

    localparam int TIMER_NUM_REGS = 4;

    // Word index inside the peripheral space
    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0,
        REG_COMPARE = 2'd1,
        REG_COUNT   = 2'd2,
        REG_STATUS  = 2'd3
    } timer_reg_e;

    // Low three bits of CTRL with enable at bit 0
    typedef struct packed {
        logic irq_en;
        logic periodic;
        logic enable;
    } timer_ctrl_t;

    typedef enum logic [1:0] {
        TIMER_IDLE = 2'd0,
        TIMER_RUN  = 2'd1,
        TIMER_DONE = 2'd2
    } timer_state_e;

endpackage

// File: verilog/system_bus_lite.sv
// ======================================================================
// Data port wins main memory. Instruction fetches above the region bit
// are never granted. Grants and read data arrive one cycle after accept.
// ======================================================================
`timescale 1ns/1ps

module system_bus_lite (
    input  logic               clk,
    input  logic               rstz,
    // Instruction port
    input  logic [31:0]        instr_addr,
    input  logic               instr_req,
    output logic [31:0]        instr_data,
    output logic               instr_gnt,
    // Data port
    input  logic [31:0]        data_addr,
    input  logic [31:0]        data_wr_data,
    input  logic [3:0]         data_wr_mask,
    input  logic               data_rd_req,
    input  logic               data_wr_req,
    output logic [31:0]        data_rd_data,
    output logic               data_gnt,
    // Main memory
    output bus_pkg::sys_addr_u mem_addr,
    output logic [31:0]        mem_wr_data,
    output logic [3:0]         mem_wr_mask,
    output logic               mem_en,
    output logic               mem_wr_en,
    input  logic [31:0]        mem_rd_data,
    // Peripheral space
    output bus_pkg::sys_addr_u periph_addr,
    output logic [31:0]        periph_wr_data,
    output logic               periph_en,
    output logic               periph_wr_en,
    input  logic [31:0]        periph_rd_data
);

    import bus_pkg::*;

    sys_addr_u instr_addr_u;
    sys_addr_u data_addr_u;
    logic      mem_instr_req;
    logic      mem_data_req;
    logic      periph_data_req;
    region_e   data_region_q;

    assign instr_addr_u.raw = instr_addr;
    assign data_addr_u.raw  = data_addr;

    // ==================================================================
    // Region decode
    assign mem_instr_req   = instr_req && (instr_addr_u.fields.region == REGION_MEM);
    assign mem_data_req    = (data_rd_req || data_wr_req)
                             && (data_addr_u.fields.region == REGION_MEM);
    assign periph_data_req = (data_rd_req || data_wr_req)
                             && (data_addr_u.fields.region == REGION_PERIPH);

    // Data access takes the memory port first
    always_comb begin
        mem_en      = mem_instr_req || mem_data_req;
        mem_wr_en   = mem_data_req && data_wr_req;
        mem_addr    = mem_data_req ? data_addr_u : instr_addr_u;
        mem_wr_data = data_wr_data;
        mem_wr_mask = data_wr_mask;
    end

    // Peripheral side sees data accesses only
    assign periph_en      = periph_data_req;
    assign periph_wr_en   = periph_data_req && data_wr_req;
    assign periph_addr    = data_addr_u;
    assign periph_wr_data = data_wr_data;

    // ==================================================================
    // Grants one cycle after accept
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            instr_gnt     <= 1'b0;
            data_gnt      <= 1'b0;
            data_region_q <= REGION_MEM;
        end else begin
            instr_gnt     <= mem_instr_req && !mem_data_req;
            data_gnt      <= mem_data_req || periph_data_req;
            data_region_q <= data_addr_u.fields.region;
        end
    end

    // Both sources return registered data in the grant cycle
    assign data_rd_data = (data_region_q == REGION_PERIPH) ? periph_rd_data : mem_rd_data;
    assign instr_data   = mem_rd_data;

endmodule

// File: verilog/memory_lite.sv
// ======================================================================
// Single port RAM, read data valid the cycle after en. Contents are
// undefined after power up. Reads during a write return the old word.
// ======================================================================
`timescale 1ns/1ps

`include "system_settings.svh"

module memory_lite (
    input  logic               clk,
    input  logic               en,
    input  logic               wr_en,
    input  bus_pkg::sys_addr_u addr,
    input  logic [31:0]        wr_data,
    input  logic [3:0]         wr_mask,
    output logic [31:0]        rd_data
);

    logic [31:0] mem [`SYSTEM_MEM_WORDS];

    // Byte lanes follow the mask
    always_ff @(posedge clk) begin
        if (en && wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    mem[addr.fields.word][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk) begin
        if (en) begin
            rd_data <= mem[addr.fields.word];
        end
    end

endmodule

// File: verilog/timer_regs.sv
// ======================================================================
// Timer registers, whole word writes only. Words past STATUS and any
// address with upper bits set read zero and drop writes.
// ======================================================================
`timescale 1ns/1ps

module timer_regs (
    input  logic                  clk,
    input  logic                  rstz,
    // Bus side
    input  logic                  en,
    input  logic                  wr_en,
    input  bus_pkg::sys_addr_u    addr,
    input  logic [31:0]           wr_data,
    output logic [31:0]           rd_data,
    // Timer core
    input  logic [31:0]           count,
    input  logic                  expire_pulse,
    output timer_pkg::timer_ctrl_t ctrl,
    output logic [31:0]           compare,
    output logic                  irq
);

    import timer_pkg::*;

    timer_reg_e reg_idx;
    logic       reg_hit;
    logic       wr_hit;
    logic       status_clr;
    logic       expired;
    logic [31:0] rd_mux;

    // ==================================================================
    // Decode
    assign reg_idx    = timer_reg_e'(addr.fields.word[1:0]);
    assign reg_hit    = (addr.fields.upper == '0) && (addr.fields.word < TIMER_NUM_REGS);
    assign wr_hit     = en && wr_en && reg_hit;
    assign status_clr = wr_hit && (reg_idx == REG_STATUS) && wr_data[0];

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ctrl    <= '0;
            compare <= '0;
        end else if (wr_hit) begin
            case (reg_idx)
                REG_CTRL:    ctrl    <= timer_ctrl_t'(wr_data[2:0]);
                REG_COMPARE: compare <= wr_data;
                default:     ;
            endcase
        end
    end

    // Expire sets, write of 1 clears; a new expire beats the clear
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            expired <= 1'b0;
        end else begin
            expired <= expire_pulse || (expired && !status_clr);
        end
    end

    // ==================================================================
    // Read back
    always_comb begin
        case (reg_idx)
            REG_CTRL:    rd_mux = {29'd0, ctrl};
            REG_COMPARE: rd_mux = compare;
            REG_COUNT:   rd_mux = count;
            REG_STATUS:  rd_mux = {31'd0, expired};
            default:     rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rd_data <= '0;
        end else begin
            rd_data <= (en && !wr_en && reg_hit) ? rd_mux : '0;
        end
    end

    assign irq = expired && ctrl.irq_en;

endmodule

// File: verilog/timer_fsm.sv
// ======================================================================
// Timer mode control. Count stays cleared while idle; dropping enable
// from any state clears it and returns to idle.
// ======================================================================
`timescale 1ns/1ps

module timer_fsm (
    input  logic                   clk,
    input  logic                   rstz,
    input  timer_pkg::timer_ctrl_t ctrl,
    input  logic                   match,
    output logic                   count_run,
    output logic                   count_clear,
    output logic                   expire_pulse
);

    import timer_pkg::*;

    timer_state_e state_q;
    timer_state_e state_d;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state_q <= TIMER_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================================
    // Next state and counter steering
    always_comb begin
        state_d      = state_q;
        count_run    = 1'b0;
        count_clear  = 1'b0;
        expire_pulse = 1'b0;

        case (state_q)
            TIMER_IDLE: begin
                count_clear = 1'b1;
                if (ctrl.enable) begin
                    state_d = TIMER_RUN;
                end
            end
            TIMER_RUN: begin
                // No tick in the match cycle, so one-shot stops on compare
                count_run = !match;
                if (!ctrl.enable) begin
                    count_clear = 1'b1;
                    state_d     = TIMER_IDLE;
                end else if (match) begin
                    expire_pulse = 1'b1;
                    if (ctrl.periodic) begin
                        count_clear = 1'b1;
                    end else begin
                        state_d = TIMER_DONE;
                    end
                end
            end
            TIMER_DONE: begin
                // Count held at compare
                if (!ctrl.enable) begin
                    count_clear = 1'b1;
                    state_d     = TIMER_IDLE;
                end
            end
            default: begin
                state_d = TIMER_IDLE;
            end
        endcase
    end

endmodule

// File: verilog/tick_counter.sv
// ======================================================================
// Prescaled 32-bit up counter. match pulses for one cycle together with
// the count value that equals compare. Clear wins over run.
// ======================================================================
`timescale 1ns/1ps

`include "system_settings.svh"

module tick_counter (
    input  logic        clk,
    input  logic        rstz,
    input  logic        count_run,
    input  logic        count_clear,
    input  logic [31:0] compare,
    output logic [31:0] count,
    output logic        match
);

    localparam int PRE_W = (`TIMER_PRESCALE > 1) ? $clog2(`TIMER_PRESCALE) : 1;

    logic [PRE_W-1:0] prescale_q;
    logic             tick;
    logic [31:0]      count_next;

    assign tick       = (prescale_q == PRE_W'(`TIMER_PRESCALE - 1));
    assign count_next = count + 32'd1;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            prescale_q <= '0;
            count      <= '0;
            match      <= 1'b0;
        end else if (count_clear) begin
            prescale_q <= '0;
            count      <= '0;
            match      <= 1'b0;
        end else begin
            match <= 1'b0;
            if (count_run) begin
                if (tick) begin
                    prescale_q <= '0;
                    count      <= count_next;
                    match      <= (count_next == compare);
                end else begin
                    prescale_q <= prescale_q + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/system_top.sv
// ======================================================================
// Bus, 4 KB memory and timer at 0x1000. irq is level, held until the
// STATUS expired flag is cleared.
// ======================================================================
`timescale 1ns/1ps

module system_top (
    input  logic        clk,
    input  logic        rstz,
    // Instruction port
    input  logic [31:0] instr_addr,
    input  logic        instr_req,
    output logic [31:0] instr_data,
    output logic        instr_gnt,
    // Data port
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wr_data,
    input  logic [3:0]  data_wr_mask,
    input  logic        data_rd_req,
    input  logic        data_wr_req,
    output logic [31:0] data_rd_data,
    output logic        data_gnt,
    // Timer interrupt
    output logic        irq
);

    import bus_pkg::*;
    import timer_pkg::*;

    sys_addr_u   mem_addr;
    logic [31:0] mem_wr_data;
    logic [3:0]  mem_wr_mask;
    logic        mem_en;
    logic        mem_wr_en;
    logic [31:0] mem_rd_data;

    sys_addr_u   periph_addr;
    logic [31:0] periph_wr_data;
    logic        periph_en;
    logic        periph_wr_en;
    logic [31:0] periph_rd_data;

    timer_ctrl_t ctrl;
    logic [31:0] compare;
    logic [31:0] count;
    logic        match;
    logic        count_run;
    logic        count_clear;
    logic        expire_pulse;

    // ==================================================================
    // Bus and memory
    system_bus_lite system_bus_lite_inst (
        .clk            (clk),
        .rstz           (rstz),
        .instr_addr     (instr_addr),
        .instr_req      (instr_req),
        .instr_data     (instr_data),
        .instr_gnt      (instr_gnt),
        .data_addr      (data_addr),
        .data_wr_data   (data_wr_data),
        .data_wr_mask   (data_wr_mask),
        .data_rd_req    (data_rd_req),
        .data_wr_req    (data_wr_req),
        .data_rd_data   (data_rd_data),
        .data_gnt       (data_gnt),
        .mem_addr       (mem_addr),
        .mem_wr_data    (mem_wr_data),
        .mem_wr_mask    (mem_wr_mask),
        .mem_en         (mem_en),
        .mem_wr_en      (mem_wr_en),
        .mem_rd_data    (mem_rd_data),
        .periph_addr    (periph_addr),
        .periph_wr_data (periph_wr_data),
        .periph_en      (periph_en),
        .periph_wr_en   (periph_wr_en),
        .periph_rd_data (periph_rd_data)
    );

    memory_lite memory_lite_inst (
        .clk     (clk),
        .en      (mem_en),
        .wr_en   (mem_wr_en),
        .addr    (mem_addr),
        .wr_data (mem_wr_data),
        .wr_mask (mem_wr_mask),
        .rd_data (mem_rd_data)
    );

    // ==================================================================
    // Timer
    timer_regs timer_regs_inst (
        .clk          (clk),
        .rstz         (rstz),
        .en           (periph_en),
        .wr_en        (periph_wr_en),
        .addr         (periph_addr),
        .wr_data      (periph_wr_data),
        .rd_data      (periph_rd_data),
        .count        (count),
        .expire_pulse (expire_pulse),
        .ctrl         (ctrl),
        .compare      (compare),
        .irq          (irq)
    );

    timer_fsm timer_fsm_inst (
        .clk          (clk),
        .rstz         (rstz),
        .ctrl         (ctrl),
        .match        (match),
        .count_run    (count_run),
        .count_clear  (count_clear),
        .expire_pulse (expire_pulse)
    );

    tick_counter tick_counter_inst (
        .clk         (clk),
        .rstz        (rstz),
        .count_run   (count_run),
        .count_clear (count_clear),
        .compare     (compare),
        .count       (count),
        .match       (match)
    );

endmodule

// File: bench/tb_system_top.sv
// ======================================================================
// Random bus traffic checked against memory and timer models. Timer
// accesses are whole words and compare values stay small.
// ======================================================================
`timescale 1ns/1ps

`include "system_settings.svh"

module tb_system_top;

    import bus_pkg::*;
    import timer_pkg::*;

    localparam int GNT_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 100;
    localparam int MEM_OPS     = 200;

    logic        clk = 1'b0;
    logic        rstz;
    logic [31:0] instr_addr;
    logic        instr_req;
    logic [31:0] instr_data;
    logic        instr_gnt;
    logic [31:0] data_addr;
    logic [31:0] data_wr_data;
    logic [3:0]  data_wr_mask;
    logic        data_rd_req;
    logic        data_wr_req;
    logic [31:0] data_rd_data;
    logic        data_gnt;
    logic        irq;

    // Memory model with one entry per word
    logic [31:0] mem_model [`SYSTEM_MEM_WORDS];
    int          errors   = 0;
    int          timeouts = 0;

    system_top system_top_inst (
        .clk          (clk),
        .rstz         (rstz),
        .instr_addr   (instr_addr),
        .instr_req    (instr_req),
        .instr_data   (instr_data),
        .instr_gnt    (instr_gnt),
        .data_addr    (data_addr),
        .data_wr_data (data_wr_data),
        .data_wr_mask (data_wr_mask),
        .data_rd_req  (data_rd_req),
        .data_wr_req  (data_wr_req),
        .data_rd_data (data_rd_data),
        .data_gnt     (data_gnt),
        .irq          (irq)
    );

    always #50 clk = ~clk;

    // ==================================================================
    // Address map and models
    function automatic logic [31:0] mem_byte_addr(input logic [WORD_W-1:0] word);
        sys_addr_u a;
        a.raw           = '0;
        a.fields.region = REGION_MEM;
        a.fields.word   = word;
        return a.raw;
    endfunction

    function automatic logic [31:0] reg_byte_addr(input timer_reg_e idx);
        sys_addr_u a;
        a.raw           = '0;
        a.fields.region = REGION_PERIPH;
        a.fields.word   = WORD_W'(idx);
        return a.raw;
    endfunction

    // Only lanes with a mask bit take the new byte
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %08h got %08h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Error counts: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // ==================================================================
    // Handshake waits sample on the falling edge
    task automatic wait_grant(input logic is_instr);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(is_instr ? instr_gnt : data_gnt) && cycles < GNT_TIMEOUT);
        if (!(is_instr ? instr_gnt : data_gnt)) begin
            $display("Timeout: %s port was not granted within %0d cycles",
                     is_instr ? "instruction" : "data", GNT_TIMEOUT);
            timeouts++;
            finish_run();
        end else begin
            check_value("grant latency", 32'd1, 32'(cycles));
        end
    endtask

    task automatic wait_irq(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!irq && cycles < limit);
        if (!irq) begin
            $display("Timeout: irq did not assert within %0d cycles", limit);
            timeouts++;
            finish_run();
        end
    endtask

    // Data port is always accepted in its first cycle
    task automatic write_data(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] mask);
        @(posedge clk);
        data_addr    <= addr;
        data_wr_data <= wdata;
        data_wr_mask <= mask;
        data_wr_req  <= 1'b1;
        @(posedge clk);
        data_wr_req  <= 1'b0;
        wait_grant(1'b0);
    endtask

    task automatic read_data(input logic [31:0] addr, output logic [31:0] rdata);
        @(posedge clk);
        data_addr   <= addr;
        data_rd_req <= 1'b1;
        @(posedge clk);
        data_rd_req <= 1'b0;
        wait_grant(1'b0);
        rdata = data_rd_data;
    endtask

    task automatic fetch_instr(input logic [31:0] addr, output logic [31:0] word);
        @(posedge clk);
        instr_addr <= addr;
        instr_req  <= 1'b1;
        @(posedge clk);
        instr_req  <= 1'b0;
        wait_grant(1'b1);
        word = instr_data;
    endtask

    // Fetch loses the first cycle to the data read
    task automatic fetch_beside_read(input logic [WORD_W-1:0] d_word,
                                     input logic [WORD_W-1:0] i_word);
        @(posedge clk);
        data_addr   <= mem_byte_addr(d_word);
        data_rd_req <= 1'b1;
        instr_addr  <= mem_byte_addr(i_word);
        instr_req   <= 1'b1;
        @(posedge clk);
        data_rd_req <= 1'b0;
        wait_grant(1'b0);
        check_value("instr_gnt beside data grant", 32'd0, 32'(instr_gnt));
        check_value("data read beside fetch", mem_model[d_word], data_rd_data);
        @(posedge clk);
        instr_req <= 1'b0;
        wait_grant(1'b1);
        check_value("fetch after data access", mem_model[i_word], instr_data);
    endtask

    // ==================================================================
    // Stimulus
    initial begin
        logic [31:0]       rdata;
        logic [31:0]       wdata;
        logic [3:0]        mask;
        logic [WORD_W-1:0] word;
        logic [31:0]       cmp;
        timer_ctrl_t       ctrl;
        int                polls;

        void'($urandom(32'h4506_0205));
        rstz         <= 1'b0;
        instr_addr   <= '0;
        instr_req    <= 1'b0;
        data_addr    <= '0;
        data_wr_data <= '0;
        data_wr_mask <= '0;
        data_rd_req  <= 1'b0;
        data_wr_req  <= 1'b0;
        repeat (10) @(posedge clk);
        rstz <= 1'b1;
        @(negedge clk);
        check_value("instr_gnt after reset", 32'd0, 32'(instr_gnt));
        check_value("data_gnt after reset", 32'd0, 32'(data_gnt));
        check_value("irq after reset", 32'd0, 32'(irq));

        // Fill every word so later partial writes have a known base
        for (int w = 0; w < `SYSTEM_MEM_WORDS; w++) begin
            wdata = $urandom();
            write_data(mem_byte_addr(WORD_W'(w)), wdata, 4'hF);
            mem_model[w] = wdata;
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            word  = WORD_W'($urandom_range(`SYSTEM_MEM_WORDS - 1));
            wdata = $urandom();
            mask  = 4'($urandom_range(15));
            write_data(mem_byte_addr(word), wdata, mask);
            mem_model[word] = merge_bytes(mem_model[word], wdata, mask);
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            word = WORD_W'($urandom_range(`SYSTEM_MEM_WORDS - 1));
            read_data(mem_byte_addr(word), rdata);
            check_value("memory read", mem_model[word], rdata);
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            word = WORD_W'($urandom_range(`SYSTEM_MEM_WORDS - 1));
            fetch_instr(mem_byte_addr(word), rdata);
            check_value("instruction fetch", mem_model[word], rdata);
        end
        for (int i = 0; i < 20; i++) begin
            fetch_beside_read(WORD_W'($urandom_range(`SYSTEM_MEM_WORDS - 1)),
                              WORD_W'($urandom_range(`SYSTEM_MEM_WORDS - 1)));
        end

        // Register readback with enable kept low
        wdata = $urandom() & 32'hFFFF_FFFE;
        write_data(reg_byte_addr(REG_CTRL), wdata, 4'hF);
        read_data(reg_byte_addr(REG_CTRL), rdata);
        check_value("CTRL readback", wdata & 32'h7, rdata);
        wdata = $urandom();
        write_data(reg_byte_addr(REG_COMPARE), wdata, 4'hF);
        read_data(reg_byte_addr(REG_COMPARE), rdata);
        check_value("COMPARE readback", wdata, rdata);
        write_data(reg_byte_addr(REG_CTRL), 32'h0, 4'hF);

        // ==============================================================
        // One-shot mode
        cmp = 32'($urandom_range(10, 3));
        write_data(reg_byte_addr(REG_COMPARE), cmp, 4'hF);
        ctrl = '{irq_en: 1'b1, periodic: 1'b0, enable: 1'b1};
        write_data(reg_byte_addr(REG_CTRL), 32'(ctrl), 4'hF);
        polls = 0;
        rdata = '0;
        while (rdata[0] == 1'b0 && polls < POLL_LIMIT) begin
            read_data(reg_byte_addr(REG_STATUS), rdata);
            polls++;
        end
        if (rdata[0] == 1'b0) begin
            $display("Timeout: one-shot timer never set its expired flag");
            timeouts++;
            finish_run();
        end
        read_data(reg_byte_addr(REG_COUNT), rdata);
        check_value("one-shot COUNT at expiry", cmp, rdata);
        repeat (3 * `TIMER_PRESCALE) @(posedge clk);
        read_data(reg_byte_addr(REG_COUNT), rdata);
        check_value("one-shot COUNT held", cmp, rdata);
        check_value("one-shot irq", 32'd1, 32'(irq));
        // irq follows irq_en while the flag stays set
        ctrl.irq_en = 1'b0;
        write_data(reg_byte_addr(REG_CTRL), 32'(ctrl), 4'hF);
        check_value("one-shot irq masked", 32'd0, 32'(irq));
        ctrl.irq_en = 1'b1;
        write_data(reg_byte_addr(REG_CTRL), 32'(ctrl), 4'hF);
        check_value("one-shot irq unmasked", 32'd1, 32'(irq));
        write_data(reg_byte_addr(REG_STATUS), 32'h1, 4'hF);
        check_value("irq after STATUS clear", 32'd0, 32'(irq));
        write_data(reg_byte_addr(REG_CTRL), 32'h0, 4'hF);

        // ==============================================================
        // Periodic mode
        cmp = 32'($urandom_range(10, 3));
        write_data(reg_byte_addr(REG_COMPARE), cmp, 4'hF);
        ctrl = '{irq_en: 1'b1, periodic: 1'b1, enable: 1'b1};
        write_data(reg_byte_addr(REG_CTRL), 32'(ctrl), 4'hF);
        for (int n = 0; n < 4; n++) begin
            wait_irq((cmp + 2) * `TIMER_PRESCALE + 10);
            read_data(reg_byte_addr(REG_COUNT), rdata);
            check_value("periodic COUNT within compare", 32'd1, 32'(rdata <= cmp));
            write_data(reg_byte_addr(REG_STATUS), 32'h1, 4'hF);
            check_value("periodic irq after clear", 32'd0, 32'(irq));
        end
        write_data(reg_byte_addr(REG_CTRL), 32'h0, 4'hF);
        read_data(reg_byte_addr(REG_COUNT), rdata);
        check_value("COUNT after disable", 32'd0, rdata);

        finish_run();
    end

endmodule

// File: sim.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/timer_pkg.sv
verilog/system_bus_lite.sv
verilog/memory_lite.sv
verilog/timer_regs.sv
verilog/timer_fsm.sv
verilog/tick_counter.sv
verilog/system_top.sv
bench/tb_system_top.sv

// File: Makefile
# Verilator build and run of the system testbench

SIM  := obj_dir/Vtb_system_top
SRCS := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sim.f $(SRCS)
	verilator --binary --timing --top-module tb_system_top -f sim.f -o Vtb_system_top

# Output goes to the terminal, status comes from the search
run: $(SIM)
	$(SIM) | tee /dev/stderr | grep -x "Test passed" > /dev/null

clean:
	rm -rf obj_dir
